//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_williams_io
RTL_TOP   ?= williams_io_top
FILELIST  ?= williams_io.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src/blank_timing.sv
`timescale 1ns/10ps

module blank_timing (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic hsync,
	input  logic vsync,
	output logic ce_pix,
	output logic hblank,
	output logic vblank
);

	logic [10:0] pcnt;
	logic [10:0] lcnt;
	logic        hs_q;
	logic        vs_q;
	logic        hs_rise;

	assign hs_rise = hsync && !hs_q;
	// Pixel clock enable at half the system rate
	assign ce_pix  = pcnt[0];

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			pcnt   <= '0;
			lcnt   <= '0;
			hs_q   <= 1'b0;
			vs_q   <= 1'b0;
			hblank <= 1'b0;
			vblank <= 1'b0;
		end
		else
		begin
			hs_q <= hsync;
			if (hs_rise)
			begin
				pcnt <= '0;
				vs_q <= vsync;
				// vsync is only looked at on line starts
				if (vsync && !vs_q)
					lcnt <= '0;
				else if (!(&lcnt))
					lcnt <= lcnt + 11'd1;
			end
			else if (!(&pcnt))
				pcnt <= pcnt + 11'd1;

			if (pcnt[10:1] == williams_av_pkg::HBLANK_ON)
				hblank <= 1'b1;
			if (pcnt[10:1] == williams_av_pkg::HBLANK_OFF)
				hblank <= 1'b0;
			if (lcnt == williams_av_pkg::VBLANK_ON)
				vblank <= 1'b1;
			if (lcnt == williams_av_pkg::VBLANK_OFF)
				vblank <= 1'b0;
		end
	end

endmodule

//--- src/control_mapper.sv
`timescale 1ns/10ps

module control_mapper (
	input  logic                                      clk_sys,
	input  logic                                      rst_n,
	input  logic [williams_game_pkg::JOY_W-1:0]       joy1,
	input  logic [williams_game_pkg::JOY_W-1:0]       joy2,
	input  logic [1:0]                                mode_sel,
	input  logic                                      sg_state,
	input  logic [williams_game_pkg::STICK_W-1:0]     sin_x,
	input  logic [williams_game_pkg::STICK_W-1:0]     sin_y,
	input  logic                                      cfg_wr,
	input  logic                                      cfg_sel,
	input  logic [7:0]                                cfg_data,
	output logic [7:0]                                ja,
	output logic [7:0]                                jb,
	output logic [2:0]                                btn,
	output logic [williams_game_pkg::DIP_W-1:0]       sw,
	output logic                                      blitter_sc2,
	output logic                                      sinistar_mode,
	output logic                                      landscape,
	output williams_game_pkg::game_variant_e          variant
);

	// {right, left, down, up}
	function automatic logic [3:0] dir4(input logic [williams_game_pkg::JOY_W-1:0] j);
		return {j[williams_game_pkg::RIGHT_BIT], j[williams_game_pkg::LEFT_BIT],
			j[williams_game_pkg::DOWN_BIT], j[williams_game_pkg::UP_BIT]};
	endfunction

	// Fire buttons laid out as a second 4-way stick
	function automatic logic [3:0] fire4(input logic [williams_game_pkg::JOY_W-1:0] j);
		return {j[williams_game_pkg::FIRE_A_BIT], j[williams_game_pkg::FIRE_D_BIT],
			j[williams_game_pkg::FIRE_B_BIT], j[williams_game_pkg::FIRE_C_BIT]};
	endfunction

	logic [williams_game_pkg::JOY_W-1:0] joy_or;
	logic [williams_game_pkg::DIP_W-1:0] dip_q;
	logic [3:0] dir_or;
	logic [5:0] fire_or;
	logic       start1, start2, coin, advance, autoup;
	logic       sg_bit4, sg_bit1;
	logic [7:0] ja_d, jb_d;
	logic [2:0] btn_d;
	logic       blit_d, sin_d, land_d;

	// Shared controls take either player
	assign joy_or  = joy1 | joy2;
	assign dir_or  = dir4(joy_or);
	assign fire_or = {joy_or[williams_game_pkg::FIRE_F_BIT], joy_or[williams_game_pkg::FIRE_E_BIT],
		joy_or[williams_game_pkg::FIRE_D_BIT], joy_or[williams_game_pkg::FIRE_C_BIT],
		joy_or[williams_game_pkg::FIRE_B_BIT], joy_or[williams_game_pkg::FIRE_A_BIT]};
	assign start1  = joy_or[williams_game_pkg::START1_BIT];
	assign start2  = joy_or[williams_game_pkg::START2_BIT];
	assign coin    = joy_or[williams_game_pkg::COIN_BIT];
	assign advance = joy_or[williams_game_pkg::ADVANCE_BIT];
	assign autoup  = joy_or[williams_game_pkg::AUTOUP_BIT];

	// Stargate reverse and thrust as buttons or following the ship's facing
	assign sg_bit4 = (mode_sel == 2'b10) ? fire_or[4] :
		(mode_sel[0] ? (sg_state ? dir_or[3] : dir_or[2]) : (dir_or[2] | dir_or[3]));
	assign sg_bit1 = mode_sel[0] ? (sg_state ? dir_or[2] : dir_or[3]) : fire_or[1];

	////////////////////
	// Per-variant layout is active high before the final inversion
	////////////////////

	always_comb
	begin
		ja_d   = '1;
		jb_d   = '1;
		btn_d  = '0;
		blit_d = 1'b0;
		sin_d  = 1'b0;
		land_d = 1'b1;
		case (variant)
			williams_game_pkg::game_robotron:
			begin
				btn_d = {start1, start2, coin};
				ja_d  = ~{mode_sel[1] ? dir4(joy2) : (mode_sel[0] ? dir_or : fire4(joy_or)),
					mode_sel[1] ? dir4(joy1) : dir_or};
				jb_d  = ja_d;
			end
			williams_game_pkg::game_joust:
			begin
				btn_d = {start2, start1, coin};
				ja_d  = ~{5'b00000, joy1[williams_game_pkg::FIRE_A_BIT],
					joy1[williams_game_pkg::RIGHT_BIT], joy1[williams_game_pkg::LEFT_BIT]};
				jb_d  = ~{5'b00000, joy2[williams_game_pkg::FIRE_A_BIT],
					joy2[williams_game_pkg::RIGHT_BIT], joy2[williams_game_pkg::LEFT_BIT]};
			end
			williams_game_pkg::game_splat:
			begin
				blit_d = 1'b1;
				btn_d  = {start1, start2, coin};
				ja_d   = ~{mode_sel[0] ? dir4(joy1) : fire4(joy1), dir4(joy1)};
				jb_d   = ~{mode_sel[0] ? dir4(joy2) : fire4(joy2), dir4(joy2)};
			end
			williams_game_pkg::game_bubbles:
			begin
				btn_d = {start2, start1, coin};
				ja_d  = ~{4'b0000, dir_or};
				jb_d  = ja_d;
			end
			williams_game_pkg::game_stargate:
			begin
				btn_d = {start2, start1, coin};
				ja_d  = ~{fire_or[5], dir_or[0], dir_or[1], sg_bit4,
					fire_or[3], fire_or[2], sg_bit1, fire_or[0]};
				jb_d  = ja_d;
			end
			williams_game_pkg::game_alienar:
			begin
				btn_d = {start1, start2, coin};
				ja_d  = ~{2'b00, joy1[williams_game_pkg::FIRE_B_BIT],
					joy1[williams_game_pkg::FIRE_A_BIT], dir4(joy1)};
				jb_d  = ~{2'b00, joy2[williams_game_pkg::FIRE_B_BIT],
					joy2[williams_game_pkg::FIRE_A_BIT], dir4(joy2)};
			end
			williams_game_pkg::game_sinistar:
			begin
				sin_d  = 1'b1;
				land_d = 1'b0;
				btn_d  = {start1, start2, coin};
				ja_d   = ~{sin_x, sin_y};
				jb_d   = ja_d;
			end
			williams_game_pkg::game_playball:
			begin
				land_d = 1'b0;
				btn_d  = {2'b00, coin};
				ja_d   = ~{4'b0000, start2, dir_or[3], dir_or[2], start1};
				jb_d   = ja_d;
			end
			default:
			begin
				// Unknown variant leaves every control released
			end
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			variant       <= williams_game_pkg::game_robotron;
			dip_q         <= '0;
			ja            <= '1;
			jb            <= '1;
			btn           <= '0;
			sw            <= '0;
			blitter_sc2   <= 1'b0;
			sinistar_mode <= 1'b0;
			landscape     <= 1'b1;
		end
		else
		begin
			if (cfg_wr && !cfg_sel)
				variant <= williams_game_pkg::game_variant_e'(cfg_data);
			if (cfg_wr && cfg_sel)
				dip_q <= cfg_data;
			ja            <= ja_d;
			jb            <= jb_d;
			btn           <= btn_d;
			sw            <= dip_q | {{(williams_game_pkg::DIP_W-2){1'b0}}, advance, autoup};
			blitter_sc2   <= blit_d;
			sinistar_mode <= sin_d;
			landscape     <= land_d;
		end
	end

endmodule

//--- src/iir_biquad.sv
`timescale 1ns/10ps

module iir_biquad #(
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] B1 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] B2 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] B3 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] A2 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] A3 = '0
) (
	input  logic                                         clk_sys,
	input  logic                                         rst_n,
	input  logic                                         stage_req,
	input  logic signed [williams_av_pkg::SAMPLE_W-1:0]  stage_in,
	output logic                                         stage_ack,
	output logic signed [williams_av_pkg::SAMPLE_W-1:0]  stage_out
);

	// Room for five products plus growth in the sum
	localparam int ACC_W = williams_av_pkg::SAMPLE_W + williams_av_pkg::COEFF_W + 3;
	localparam logic signed [ACC_W-1:0] SAT_HI =
		{{(ACC_W-williams_av_pkg::SAMPLE_W+1){1'b0}}, {(williams_av_pkg::SAMPLE_W-1){1'b1}}};
	localparam logic signed [ACC_W-1:0] SAT_LO = ~SAT_HI;

	logic signed [williams_av_pkg::SAMPLE_W-1:0] x0, x1, x2, y2;
	logic signed [williams_av_pkg::SAMPLE_W-1:0] y_sat;
	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] acc_sh;
	logic capture_q;
	logic calc_q;

	assign acc_sh = acc >>> williams_av_pkg::COEFF_SCALE;

	always_comb
	begin
		if (acc_sh > SAT_HI)
			y_sat = SAT_HI[williams_av_pkg::SAMPLE_W-1:0];
		else if (acc_sh < SAT_LO)
			y_sat = SAT_LO[williams_av_pkg::SAMPLE_W-1:0];
		else
			y_sat = acc_sh[williams_av_pkg::SAMPLE_W-1:0];
	end

	// Sample and sum, stage_out doubles as the y1 history tap
	always_ff @(posedge clk_sys)
	begin
		if (!stage_ack && !capture_q && !calc_q && stage_req)
			x0 <= stage_in;
		if (capture_q)
			acc <= B1 * x0 + B2 * x1 + B3 * x2 - A2 * stage_out - A3 * y2;
	end

	////////////////////
	// Handshake and history
	////////////////////

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			capture_q <= 1'b0;
			calc_q    <= 1'b0;
			stage_ack <= 1'b0;
			x1        <= '0;
			x2        <= '0;
			y2        <= '0;
			stage_out <= '0;
		end
		else
		begin
			capture_q <= !stage_ack && !capture_q && !calc_q && stage_req;
			calc_q    <= capture_q;
			if (calc_q)
			begin
				x1        <= x0;
				x2        <= x1;
				y2        <= stage_out;
				stage_out <= y_sat;
				stage_ack <= 1'b1;
			end
			else if (stage_ack && !stage_req)
				stage_ack <= 1'b0;
		end
	end

endmodule

//--- src/sound_mixer.sv
`timescale 1ns/10ps

module sound_mixer #(
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] S1_B1 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] S1_B2 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] S1_B3 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] S1_A2 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] S1_A3 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] S2_B1 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] S2_B2 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] S2_B3 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] S2_A2 = '0,
	parameter logic signed [williams_av_pkg::COEFF_W-1:0] S2_A3 = '0
) (
	input  logic                                  clk_sys,
	input  logic                                  rst_n,
	input  logic [williams_av_pkg::SAMPLE_W-1:0]  speech,
	input  logic                                  speech_req,
	input  logic [williams_av_pkg::SOUND_W-1:0]   sound,
	input  williams_game_pkg::game_variant_e      variant,
	output logic                                  speech_ack,
	output logic [15:0]                           audio_l
);

	williams_av_pkg::speech_state_e state;

	logic [williams_av_pkg::SAMPLE_W-1:0] smp_q, spch_q, filt_u;
	logic signed [williams_av_pkg::SAMPLE_W-1:0] s_in, s1_out, s2_out, s_final;
	logic signed [williams_av_pkg::SAMPLE_W+1:0] boosted;
	logic [williams_av_pkg::MIX_W-1:0] mix_sum;
	logic s1_req, s1_ack, s2_req, s2_ack;

	// Offset binary to signed for the filters
	assign s_in = smp_q - 16'h8000;

	iir_biquad #(.B1(S1_B1), .B2(S1_B2), .B3(S1_B3), .A2(S1_A2), .A3(S1_A3)) stage1_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.stage_req (s1_req),
		.stage_in  (s_in),
		.stage_ack (s1_ack),
		.stage_out (s1_out)
	);

	iir_biquad #(.B1(S2_B1), .B2(S2_B2), .B3(S2_B3), .A2(S2_A2), .A3(S2_A3)) stage2_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.stage_req (s2_req),
		.stage_in  (s1_out),
		.stage_ack (s2_ack),
		.stage_out (s2_out)
	);

	////////////////////
	// Gain of four with clipping
	////////////////////

	assign boosted = {{2{s2_out[williams_av_pkg::SAMPLE_W-1]}}, s2_out} <<< 2;

	always_comb
	begin
		if (boosted > 18'sd32767)
			s_final = 16'sh7fff;
		else if (boosted < -18'sd32768)
			s_final = 16'sh8000;
		else
			s_final = boosted[williams_av_pkg::SAMPLE_W-1:0];
	end

	assign filt_u  = s_final + 16'h8000;
	assign mix_sum = {1'b0, sound, 8'd0} + {1'b0, spch_q};

	always_ff @(posedge clk_sys)
	begin
		if (state == williams_av_pkg::st_idle && speech_req)
			smp_q <= speech;
		audio_l <= {2'b00, mix_sum[williams_av_pkg::MIX_W-1:3]};
	end

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			state      <= williams_av_pkg::st_idle;
			s1_req     <= 1'b0;
			s2_req     <= 1'b0;
			speech_ack <= 1'b0;
			spch_q     <= 16'h8000;
		end
		else
		begin
			case (state)
				williams_av_pkg::st_idle:
				begin
					if (speech_req)
					begin
						s1_req <= 1'b1;
						state  <= williams_av_pkg::st_stage1;
					end
				end
				williams_av_pkg::st_stage1:
				begin
					if (s1_ack)
					begin
						s1_req <= 1'b0;
						s2_req <= 1'b1;
						state  <= williams_av_pkg::st_stage2;
					end
				end
				williams_av_pkg::st_stage2:
				begin
					if (s2_ack)
					begin
						s2_req <= 1'b0;
						state  <= williams_av_pkg::st_mix;
					end
				end
				williams_av_pkg::st_mix:
				begin
					// Only sinistar takes the filtered speech
					spch_q <= (variant == williams_game_pkg::game_sinistar) ? filt_u : smp_q;
					state  <= williams_av_pkg::st_done;
				end
				default:
				begin
					// audio_l picks up the new value on the same edge that raises ack
					if (!speech_ack)
						speech_ack <= 1'b1;
					else if (!speech_req)
					begin
						speech_ack <= 1'b0;
						state      <= williams_av_pkg::st_idle;
					end
				end
			endcase
		end
	end

endmodule

//--- src/stick_quantizer.sv
`timescale 1ns/10ps

module stick_quantizer (
	input  logic                                  clk_sys,
	input  logic                                  rst_n,
	input  logic [williams_game_pkg::JOY_W-1:0]   joy1,
	input  logic [williams_game_pkg::JOY_W-1:0]   joy2,
	input  logic [15:0]                           joy1_analog,
	input  logic [15:0]                           joy2_analog,
	output logic [williams_game_pkg::STICK_W-1:0] sin_x,
	output logic [williams_game_pkg::STICK_W-1:0] sin_y
);

	// Thresholds at 32, 64 and 96; the y axis swaps the negative and positive codes
	function automatic logic [williams_game_pkg::STICK_W-1:0] quant_axis(
		input logic signed [7:0] v,
		input logic              mirror
	);
		logic [11:0] neg_codes;
		logic [11:0] pos_codes;
		neg_codes = mirror ? {4'd8, 4'd9, 4'd11} : {4'd0, 4'd4, 4'd6};
		pos_codes = mirror ? {4'd0, 4'd4, 4'd6} : {4'd8, 4'd9, 4'd11};
		if (v < -8'sd96)
			return neg_codes[11:8];
		if (v < -8'sd64)
			return neg_codes[7:4];
		if (v < -8'sd32)
			return neg_codes[3:0];
		if (v > 8'sd96)
			return pos_codes[11:8];
		if (v > 8'sd64)
			return pos_codes[7:4];
		if (v > 8'sd32)
			return pos_codes[3:0];
		return 4'd7;
	endfunction

	logic        p2_q;
	logic        use_p2;
	logic [15:0] analog;
	logic [williams_game_pkg::JOY_W-1:0] joy_or;
	logic [williams_game_pkg::STICK_W-1:0] ana_x, ana_y, dig_x, dig_y;

	// Player 1 wins when both touch their sticks in the same cycle
	assign use_p2 = (|joy1) ? 1'b0 : ((|joy2) ? 1'b1 : p2_q);
	assign analog = use_p2 ? joy2_analog : joy1_analog;

	assign ana_x = quant_axis(analog[7:0], 1'b0);
	assign ana_y = quant_axis(analog[15:8], 1'b1);

	assign joy_or = joy1 | joy2;
	assign dig_x  = joy_or[williams_game_pkg::LEFT_BIT] ? 4'd0 :
		(joy_or[williams_game_pkg::RIGHT_BIT] ? 4'd8 : 4'd7);
	assign dig_y  = joy_or[williams_game_pkg::DOWN_BIT] ? 4'd0 :
		(joy_or[williams_game_pkg::UP_BIT] ? 4'd8 : 4'd7);

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			p2_q  <= 1'b0;
			sin_x <= 4'd7;
			sin_y <= 4'd7;
		end
		else
		begin
			p2_q  <= use_p2;
			// Centred analog axis falls back to the digital stick
			sin_x <= (ana_x == 4'd7) ? dig_x : ana_x;
			sin_y <= (ana_y == 4'd7) ? dig_y : ana_y;
		end
	end

endmodule

//--- src/williams_av_pkg.sv
package williams_av_pkg;

	////////////////////
	// Audio formats
	////////////////////

	localparam int SAMPLE_W = 16;
	localparam int SOUND_W  = 8;
	localparam int MIX_W    = 17;

	// Filter coefficients are signed fixed point with COEFF_SCALE fraction bits
	localparam int COEFF_W     = 22;
	localparam int COEFF_SCALE = 15;

	////////////////////
	// Blanking thresholds
	////////////////////

	// Horizontal values compare against the pixel counter divided by two
	localparam logic [9:0]  HBLANK_ON  = 10'd336;
	localparam logic [9:0]  HBLANK_OFF = 10'd40;
	localparam logic [10:0] VBLANK_ON  = 11'd254;
	localparam logic [10:0] VBLANK_OFF = 11'd14;

	// Speech sequencer in sound_mixer
	typedef enum logic [2:0] {
		st_idle,
		st_stage1,
		st_stage2,
		st_mix,
		st_done
	} speech_state_e;

endpackage

//--- src/williams_game_pkg.sv
package williams_game_pkg;

	// Board variants, as loaded through the config port
	typedef enum logic [7:0] {
		game_robotron = 8'd0,
		game_joust    = 8'd1,
		game_splat    = 8'd2,
		game_bubbles  = 8'd3,
		game_stargate = 8'd4,
		game_alienar  = 8'd5,
		game_sinistar = 8'd6,
		game_playball = 8'd7
	} game_variant_e;

	////////////////////
	// Digital joystick word
	////////////////////

	localparam int JOY_W = 16;

	localparam int RIGHT_BIT   = 0;
	localparam int LEFT_BIT    = 1;
	localparam int DOWN_BIT    = 2;
	localparam int UP_BIT      = 3;
	localparam int FIRE_A_BIT  = 4;
	localparam int FIRE_B_BIT  = 5;
	localparam int FIRE_C_BIT  = 6;
	localparam int FIRE_D_BIT  = 7;
	localparam int FIRE_E_BIT  = 8;
	localparam int FIRE_F_BIT  = 9;
	localparam int START1_BIT  = 10;
	localparam int START2_BIT  = 11;
	localparam int COIN_BIT    = 12;
	localparam int ADVANCE_BIT = 13;
	localparam int AUTOUP_BIT  = 14;

	// One sinistar axis position
	localparam int STICK_W = 4;

	localparam int DIP_W = 8;

endpackage

//--- src/williams_io_top.sv
`timescale 1ns/10ps

module williams_io_top (
	input  logic                                  clk_sys,
	input  logic                                  rst_n,
	input  logic [williams_game_pkg::JOY_W-1:0]   joy1,
	input  logic [williams_game_pkg::JOY_W-1:0]   joy2,
	input  logic [15:0]                           joy1_analog,
	input  logic [15:0]                           joy2_analog,
	input  logic [1:0]                            mode_sel,
	input  logic                                  sg_state,
	input  logic                                  cfg_wr,
	input  logic                                  cfg_sel,
	input  logic [7:0]                            cfg_data,
	input  logic [williams_av_pkg::SOUND_W-1:0]   sound,
	input  logic [williams_av_pkg::SAMPLE_W-1:0]  speech,
	input  logic                                  speech_req,
	output logic                                  speech_ack,
	output logic [15:0]                           audio_l,
	output logic [7:0]                            ja,
	output logic [7:0]                            jb,
	output logic [2:0]                            btn,
	output logic [williams_game_pkg::DIP_W-1:0]   sw,
	output logic                                  blitter_sc2,
	output logic                                  sinistar_mode,
	output logic                                  landscape,
	input  logic                                  hsync,
	input  logic                                  vsync,
	output logic                                  ce_pix,
	output logic                                  hblank,
	output logic                                  vblank
);

	logic [williams_game_pkg::STICK_W-1:0] sin_x;
	logic [williams_game_pkg::STICK_W-1:0] sin_y;
	williams_game_pkg::game_variant_e      variant;

	////////////////////
	// Controls
	////////////////////

	stick_quantizer stick_quantizer_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.joy1        (joy1),
		.joy2        (joy2),
		.joy1_analog (joy1_analog),
		.joy2_analog (joy2_analog),
		.sin_x       (sin_x),
		.sin_y       (sin_y)
	);

	control_mapper control_mapper_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.joy1          (joy1),
		.joy2          (joy2),
		.mode_sel      (mode_sel),
		.sg_state      (sg_state),
		.sin_x         (sin_x),
		.sin_y         (sin_y),
		.cfg_wr        (cfg_wr),
		.cfg_sel       (cfg_sel),
		.cfg_data      (cfg_data),
		.ja            (ja),
		.jb            (jb),
		.btn           (btn),
		.sw            (sw),
		.blitter_sc2   (blitter_sc2),
		.sinistar_mode (sinistar_mode),
		.landscape     (landscape),
		.variant       (variant)
	);

	////////////////////
	// Audio and video
	////////////////////

	// Two near-Butterworth low-pass sections modelled on the sound board op-amps
	sound_mixer #(
		.S1_B1 (22'sd701),
		.S1_B2 (22'sd1401),
		.S1_B3 (22'sd701),
		.S1_A2 (-22'sd50452),
		.S1_A3 (22'sd20486),
		.S2_B1 (22'sd650),
		.S2_B2 (22'sd1301),
		.S2_B3 (22'sd650),
		.S2_A2 (-22'sd51122),
		.S2_A3 (22'sd20955)
	) sound_mixer_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.speech     (speech),
		.speech_req (speech_req),
		.sound      (sound),
		.variant    (variant),
		.speech_ack (speech_ack),
		.audio_l    (audio_l)
	);

	blank_timing blank_timing_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.hsync   (hsync),
		.vsync   (vsync),
		.ce_pix  (ce_pix),
		.hblank  (hblank),
		.vblank  (vblank)
	);

endmodule

//--- tests/tb_williams_io.sv
`timescale 1ns/10ps

module tb_williams_io;

	localparam int MAP_ITERS    = 20;
	localparam int STICK_ITERS  = 20;
	localparam int SPEECH_ITERS = 40;
	localparam int LINE_LEN     = 800;
	localparam int FRAME_LINES  = 270;
	localparam int RUN_LINES    = 300;
	// Rough cycle budget of all tests with half again as margin
	localparam longint TEST_CYCLES = 10 + 8 * (MAP_ITERS * 6 + 4) + 3 * STICK_ITERS * 6
		+ 2 * SPEECH_ITERS * 30 + RUN_LINES * LINE_LEN;
	localparam longint WATCHDOG_NS = TEST_CYCLES * 3 / 2 * 100;

	logic        clk_sys;
	logic        rst_n;
	logic [15:0] joy1, joy2, joy1_analog, joy2_analog;
	logic [1:0]  mode_sel;
	logic        sg_state, cfg_wr, cfg_sel;
	logic [7:0]  cfg_data, sound;
	logic [15:0] speech, audio_l;
	logic        speech_req, speech_ack;
	logic [7:0]  ja, jb, sw;
	logic [2:0]  btn;
	logic        blitter_sc2, sinistar_mode, landscape;
	logic        hsync, vsync, ce_pix, hblank, vblank;

	logic [31:0] lfsr_state = 32'ha9529219;
	int          checks = 0;
	int          errors = 0;
	logic        last_p2 = 1'b0;
	logic [7:0]  cur_variant = 8'd0;
	logic [7:0]  cur_dip = 8'd0;

	// Reference filter history with one entry per stage
	longint fx1[2], fx2[2], fy1[2], fy2[2];
	longint cb1[2] = '{701, 650};
	longint cb2[2] = '{1401, 1301};
	longint cb3[2] = '{701, 650};
	longint ca2[2] = '{-50452, -51122};
	longint ca3[2] = '{20486, 20955};

	williams_io_top williams_io_top_i (.*);

	always #50 clk_sys = ~clk_sys;

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: the tests did not finish in the expected time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA3000000) : (lfsr_state >> 1);
		end
		return r;
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	////////////////////
	// Reference models
	////////////////////

	function automatic logic [3:0] axis_code(input logic signed [7:0] v, input logic mirror,
		input logic lo, input logic hi);
		int code;
		if (v < -96)
			code = mirror ? 8 : 0;
		else if (v < -64)
			code = mirror ? 9 : 4;
		else if (v < -32)
			code = mirror ? 11 : 6;
		else if (v > 96)
			code = mirror ? 0 : 8;
		else if (v > 64)
			code = mirror ? 4 : 9;
		else if (v > 32)
			code = mirror ? 6 : 11;
		else
			code = 7;
		// Centred stick uses the digital direction
		if (code == 7)
			code = lo ? 0 : (hi ? 8 : 7);
		return code[3:0];
	endfunction

	// Returns {ja, jb, btn, landscape, blitter_sc2, sinistar_mode} with ja and jb active low
	function automatic logic [21:0] map_controls(input logic [7:0] game, input logic [15:0] j1,
		input logic [15:0] j2, input logic [1:0] mode, input logic sg, input logic [7:0] stick);
		logic [15:0] o;
		logic [3:0]  d1, d2, dor, f4;
		logic [7:0]  a, b;
		logic [2:0]  bt;
		logic        land, b4, b1;
		logic        blit, sinm, per_player;
		o    = j1 | j2;
		d1   = {j1[0], j1[1], j1[2], j1[3]};
		d2   = {j2[0], j2[1], j2[2], j2[3]};
		dor  = {o[0], o[1], o[2], o[3]};
		f4   = {o[4], o[7], o[5], o[6]};
		land = 1'b1;
		bt   = {o[10], o[11], o[12]};
		a    = 8'h00;
		b    = 8'h00;
		blit = 1'b0;
		sinm = 1'b0;
		per_player = 1'b0;
		case (game)
			8'd0: a = {mode[1] ? d2 : (mode[0] ? dor : f4), mode[1] ? d1 : dor};
			8'd1:
			begin
				per_player = 1'b1;
				bt = {o[11], o[10], o[12]};
				a  = {5'b0, j1[4], j1[0], j1[1]};
				b  = {5'b0, j2[4], j2[0], j2[1]};
			end
			8'd2:
			begin
				per_player = 1'b1;
				blit = 1'b1;
				a = {mode[0] ? d1 : {j1[4], j1[7], j1[5], j1[6]}, d1};
				b = {mode[0] ? d2 : {j2[4], j2[7], j2[5], j2[6]}, d2};
			end
			8'd3:
			begin
				bt = {o[11], o[10], o[12]};
				a  = {4'b0, dor};
			end
			8'd4:
			begin
				bt = {o[11], o[10], o[12]};
				b4 = (mode == 2'b10) ? o[8] : (mode[0] ? (sg ? o[0] : o[1]) : (o[0] | o[1]));
				b1 = mode[0] ? (sg ? o[1] : o[0]) : o[5];
				a  = {o[9], o[3], o[2], b4, o[7], o[6], b1, o[4]};
			end
			8'd5:
			begin
				per_player = 1'b1;
				a = {2'b0, j1[5], j1[4], d1};
				b = {2'b0, j2[5], j2[4], d2};
			end
			8'd6:
			begin
				land = 1'b0;
				sinm = 1'b1;
				a    = stick;
			end
			default:
			begin
				land = 1'b0;
				bt   = {2'b0, o[12]};
				a    = {4'b0, o[11], o[0], o[1], o[10]};
			end
		endcase
		if (!per_player)
			b = a;
		return {~a, ~b, bt, land, blit, sinm};
	endfunction

	function automatic logic [7:0] ref_stick(input logic [15:0] j1, input logic [15:0] j2,
		input logic [15:0] an);
		logic [15:0] o;
		o = j1 | j2;
		return {axis_code(an[7:0], 1'b0, o[1], o[0]), axis_code(an[15:8], 1'b1, o[2], o[3])};
	endfunction

	task automatic filter_stage(input int s, input longint x, output longint y);
		longint acc;
		acc = cb1[s] * x + cb2[s] * fx1[s] + cb3[s] * fx2[s] - ca2[s] * fy1[s] - ca3[s] * fy2[s];
		y = acc >>> 15;
		if (y > 32767)
			y = 32767;
		if (y < -32768)
			y = -32768;
		fx2[s] = fx1[s];
		fx1[s] = x;
		fy2[s] = fy1[s];
		fy1[s] = y;
	endtask

	task automatic ref_audio(input logic [15:0] raw, input logic [7:0] snd, input logic sin,
		output logic [15:0] exp);
		longint y1, y2, g;
		logic [15:0] spch;
		logic [16:0] mix;
		filter_stage(0, longint'(raw) - 32768, y1);
		filter_stage(1, y1, y2);
		g = y2 * 4;
		if (g > 32767)
			g = 32767;
		if (g < -32768)
			g = -32768;
		spch = sin ? 16'(g + 32768) : raw;
		mix  = {1'b0, snd, 8'd0} + {1'b0, spch};
		exp  = {2'b00, mix[16:3]};
	endtask

	////////////////////
	// Stimulus helpers
	////////////////////

	task automatic write_cfg(input logic sel, input logic [7:0] data);
		@(posedge clk_sys);
		cfg_wr   <= 1'b1;
		cfg_sel  <= sel;
		cfg_data <= data;
		@(posedge clk_sys);
		cfg_wr   <= 1'b0;
	endtask

	task automatic drive_and_check(input logic [15:0] j1, input logic [15:0] j2,
		input logic [15:0] a1, input logic [15:0] a2, input logic [1:0] mode, input logic sg);
		logic [21:0] exp;
		@(posedge clk_sys);
		joy1 <= j1;
		joy2 <= j2;
		joy1_analog <= a1;
		joy2_analog <= a2;
		mode_sel <= mode;
		sg_state <= sg;
		if (j1 != 0)
			last_p2 = 1'b0;
		else if (j2 != 0)
			last_p2 = 1'b1;
		exp = map_controls(cur_variant, j1, j2, mode, sg, ref_stick(j1, j2, last_p2 ? a2 : a1));
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		compare("ja", ja, exp[21:14]);
		compare("jb", jb, exp[13:6]);
		compare("btn", btn, exp[5:3]);
		compare("landscape", landscape, exp[2]);
		compare("blitter_sc2", blitter_sc2, exp[1]);
		compare("sinistar_mode", sinistar_mode, exp[0]);
		compare("sw", sw, cur_dip | {6'b0, j1[13] | j2[13], j1[14] | j2[14]});
	endtask

	task automatic send_speech(input logic [15:0] smp, input logic [7:0] snd);
		logic [15:0] exp;
		int          n;
		ref_audio(smp, snd, cur_variant == 8'd6, exp);
		@(posedge clk_sys);
		speech     <= smp;
		sound      <= snd;
		speech_req <= 1'b1;
		n = 0;
		do
		begin
			@(negedge clk_sys);
			n++;
		end
		while (!speech_ack && n < 100);
		if (!speech_ack)
		begin
			errors++;
			$display("Speech sample was never acknowledged within 100 cycles");
		end
		compare("audio_l", audio_l, exp);
		@(negedge clk_sys);
		compare("speech_ack held while req high", speech_ack, 1'b1);
		@(posedge clk_sys);
		speech_req <= 1'b0;
		n = 0;
		do
		begin
			@(negedge clk_sys);
			n++;
		end
		while (speech_ack && n < 20);
		if (speech_ack)
		begin
			errors++;
			$display("speech_ack did not fall after speech_req was dropped");
		end
	endtask

	// Cycle model of the blanking counters for the falling-edge checks
	logic [10:0] rp, rl;
	logic        rhs, rvs, rhb, rvb, blank_on = 1'b0;

	always @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			rp = 0;
			rl = 0;
			rhs = 0;
			rvs = 0;
			rhb = 0;
			rvb = 0;
		end
		else
		begin
			if (rp / 2 == 336)
				rhb = 1'b1;
			if (rp / 2 == 40)
				rhb = 1'b0;
			if (rl == 254)
				rvb = 1'b1;
			if (rl == 14)
				rvb = 1'b0;
			if (hsync && !rhs)
			begin
				rp = 0;
				rl = (vsync && !rvs) ? 11'd0 : ((rl == 11'h7ff) ? rl : rl + 1);
				rvs = vsync;
			end
			else if (rp != 11'h7ff)
				rp = rp + 1;
			rhs = hsync;
		end
	end

	always @(negedge clk_sys)
	begin
		if (blank_on)
		begin
			compare("hblank", hblank, rhb);
			compare("vblank", vblank, rvb);
			compare("ce_pix", ce_pix, rp[0]);
		end
	end

	task automatic report(input string name, input int err_before);
		if (errors == err_before)
			$display("%s: passed", name);
		else
			$display("%s: failed with %0d errors", name, errors - err_before);
	endtask

	initial
	begin
		int e0;
		int vb_rises;
		logic [15:0] j;
		logic [3:0]  rx;
		logic [3:0]  ry;
		clk_sys = 0;
		rst_n = 0;
		joy1 = 0;
		joy2 = 0;
		joy1_analog = 0;
		joy2_analog = 0;
		mode_sel = 0;
		sg_state = 0;
		cfg_wr = 0;
		cfg_sel = 0;
		cfg_data = 0;
		sound = 0;
		speech = 16'h8000;
		speech_req = 0;
		hsync = 0;
		vsync = 0;
		fx1 = '{0, 0};
		fx2 = '{0, 0};
		fy1 = '{0, 0};
		fy2 = '{0, 0};
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;

		// Reset values
		e0 = errors;
		@(negedge clk_sys);
		compare("ja", ja, 8'hff);
		compare("jb", jb, 8'hff);
		compare("btn", btn, 3'b000);
		compare("speech_ack", speech_ack, 1'b0);
		compare("audio_l", audio_l, 16'h1000);
		compare("hblank", hblank, 1'b0);
		compare("vblank", vblank, 1'b0);
		report("reset values", e0);

		// Every variant with random controls
		e0 = errors;
		for (int v = 0; v < 8; v++)
		begin
			cur_variant = v[7:0];
			cur_dip = rand_bits(8);
			write_cfg(1'b0, cur_variant);
			write_cfg(1'b1, cur_dip);
			for (int i = 0; i < MAP_ITERS; i++)
				drive_and_check(rand_bits(15), rand_bits(15), rand_bits(16), rand_bits(16),
					rand_bits(2), rand_bits(1));
		end
		report("variant mapping", e0);

		// Sinistar stick per player and centred with directions
		e0 = errors;
		cur_variant = 8'd6;
		write_cfg(1'b0, cur_variant);
		for (int i = 0; i < STICK_ITERS; i++)
		begin
			j = 16'h0010 | 16'(rand_bits(4));
			drive_and_check(j, 16'h0, rand_bits(16), rand_bits(16), 2'b00, 1'b0);
			drive_and_check(16'h0, j, rand_bits(16), rand_bits(16), 2'b00, 1'b0);
			rx = 4'(rand_bits(4));
			ry = 4'(rand_bits(4));
			drive_and_check(16'h0, 16'h0, rand_bits(16), {1'b0, ry, 3'b000, 1'b0, rx, 3'b000},
				2'b00, 1'b0);
			drive_and_check(rand_bits(4), 16'h0, 16'h0000, 16'h7f80, 2'b00, 1'b0);
		end
		report("sinistar stick", e0);

		// Speech samples filtered then raw
		e0 = errors;
		for (int i = 0; i < SPEECH_ITERS; i++)
			send_speech(rand_bits(16), rand_bits(8));
		cur_variant = 8'd0;
		write_cfg(1'b0, cur_variant);
		for (int i = 0; i < SPEECH_ITERS; i++)
			send_speech(rand_bits(16), rand_bits(8));
		report("speech path", e0);

		// Blanking over a frame and a bit
		e0 = errors;
		vb_rises = 0;
		blank_on = 1'b1;
		for (int l = 0; l < RUN_LINES; l++)
		begin
			for (int c = 0; c < LINE_LEN; c++)
			begin
				@(posedge clk_sys);
				if (vblank && c == 0 && rl == 254)
					vb_rises++;
				hsync <= (c == 0);
				vsync <= ((l % FRAME_LINES) < 3);
			end
		end
		blank_on = 1'b0;
		if (vb_rises == 0)
		begin
			errors++;
			$display("vblank never became active during the blanking test");
		end
		report("blanking", e0);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- williams_io.f
src/williams_game_pkg.sv
src/williams_av_pkg.sv
src/control_mapper.sv
src/stick_quantizer.sv
src/iir_biquad.sv
src/sound_mixer.sv
src/blank_timing.sv
src/williams_io_top.sv
tests/tb_williams_io.sv
